/* common/exu_pkg.sv */
package exu_pkg;

   localparam int xlen       = 32;
   localparam int reg_addr_w = 5;
   localparam int reg_count  = 32;
   localparam int inst_bytes = 4;

   typedef logic [xlen-1:0]       data_t;
   typedef logic [reg_addr_w-1:0] reg_addr_t;

   typedef enum logic [1:0] {
      unit_alu,
      unit_bru,
      unit_mul
   } unit_t;

   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_slt,
      alu_sltu,
      alu_and,
      alu_or,
      alu_xor,
      alu_nor,
      alu_sll,
      alu_srl,
      alu_sra,
      alu_pass_b
   } alu_op_t;

   typedef enum logic [3:0] {
      bru_beq,
      bru_bne,
      bru_blt,
      bru_bge,
      bru_bltu,
      bru_bgeu,
      bru_b,
      bru_bl,
      bru_jirl
   } bru_op_t;

   typedef enum logic [1:0] {
      mul_lo,
      mul_hi_s,
      mul_hi_u
   } mul_op_t;

   // one decoded instruction in E
   typedef struct packed {
      logic      valid;
      unit_t     unit;
      alu_op_t   alu_op;
      bru_op_t   bru_op;
      mul_op_t   mul_op;
      data_t     a;
      data_t     b;
      data_t     offset;
      data_t     pc;
      reg_addr_t rd;
      logic      wen;
   } exu_issue_t;

   typedef struct packed {
      logic  taken;
      data_t target;
   } br_redirect_t;

   typedef struct packed {
      logic      wen;
      reg_addr_t rd;
      data_t     data;
   } wb_t;

endpackage

/* source/alu.sv */
`timescale 1ns/100ps

module alu (
   input  exu_pkg::data_t   a,
   input  exu_pkg::data_t   b,
   input  exu_pkg::alu_op_t op,
   output exu_pkg::data_t   res
);
   import exu_pkg::*;

   logic [$clog2(xlen)-1:0] shamt;

   assign shamt = b[$clog2(xlen)-1:0];

   always_comb begin
      case (op)
         alu_add: begin
            res = a + b;
         end
         alu_sub: begin
            res = a - b;
         end
         alu_slt: begin
            res = data_t'($signed(a) < $signed(b));
         end
         alu_sltu: begin
            res = data_t'(a < b);
         end
         alu_and: begin
            res = a & b;
         end
         alu_or: begin
            res = a | b;
         end
         alu_xor: begin
            res = a ^ b;
         end
         alu_nor: begin
            res = ~(a | b);
         end
         alu_sll: begin
            res = a << shamt;
         end
         alu_srl: begin
            res = a >> shamt;
         end
         alu_sra: begin
            res = data_t'($signed(a) >>> shamt);
         end
         // lu12i style, immediate already placed in b
         alu_pass_b: begin
            res = b;
         end
         default: begin
            res = '0;
         end
      endcase
   end

endmodule

/* source/branch_unit.sv */
`timescale 1ns/100ps

module branch_unit (
   input  logic                  valid,
   input  exu_pkg::bru_op_t      op,
   input  exu_pkg::data_t        a,
   input  exu_pkg::data_t        b,
   input  exu_pkg::data_t        pc,
   input  exu_pkg::data_t        offset,
   output exu_pkg::br_redirect_t redirect,
   output exu_pkg::data_t        link_pc
);
   import exu_pkg::*;

   logic  cond;
   data_t base;

   always_comb begin
      case (op)
         bru_beq:  cond = (a == b);
         bru_bne:  cond = (a != b);
         bru_blt:  cond = ($signed(a) < $signed(b));
         bru_bge:  cond = ($signed(a) >= $signed(b));
         bru_bltu: cond = (a < b);
         bru_bgeu: cond = (a >= b);
         bru_b,
         bru_bl,
         bru_jirl: cond = 1'b1;
         default:  cond = 1'b0;
      endcase
   end

   // jirl jumps relative to the register, the rest to pc
   assign base = (op == bru_jirl) ? a : pc;

   assign redirect.taken  = valid & cond;
   assign redirect.target = base + offset;

   assign link_pc = pc + data_t'(inst_bytes);

endmodule

/* source/mul_pipe.sv */
`timescale 1ns/100ps

module mul_pipe (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               valid,
   input  exu_pkg::data_t     a,
   input  exu_pkg::data_t     b,
   input  exu_pkg::mul_op_t   op,
   input  exu_pkg::reg_addr_t rd,
   input  logic               wen,
   output exu_pkg::data_t     res,
   output logic               done,
   output exu_pkg::reg_addr_t rd_out,
   output logic               wen_out
);
   import exu_pkg::*;

   typedef struct packed {
      logic signed [33:0] pp_ll;
      logic signed [33:0] pp_lh;
      logic signed [33:0] pp_hl;
      logic signed [33:0] pp_hh;
      mul_op_t            op;
      reg_addr_t          rd;
      logic               wen;
   } mul_s1_t;

   mul_s1_t            s1;
   logic               s1_valid;
   logic               sgn;
   logic signed [16:0] a_lo;
   logic signed [16:0] a_hi;
   logic signed [16:0] b_lo;
   logic signed [16:0] b_hi;
   logic signed [63:0] prod;

   function automatic logic signed [63:0] sext_pp(input logic [33:0] pp);
      return {{30{pp[33]}}, pp};
   endfunction

   // low halves are always unsigned, high halves carry the sign
   assign sgn  = (op == mul_hi_s);
   assign a_lo = {1'b0, a[15:0]};
   assign b_lo = {1'b0, b[15:0]};
   assign a_hi = {sgn & a[31], a[31:16]};
   assign b_hi = {sgn & b[31], b[31:16]};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1_valid <= 1'b0;
         done     <= 1'b0;
      end else begin
         s1_valid <= valid;
         done     <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      s1.pp_ll <= a_lo * b_lo;
      s1.pp_lh <= a_lo * b_hi;
      s1.pp_hl <= a_hi * b_lo;
      s1.pp_hh <= a_hi * b_hi;
      s1.op    <= op;
      s1.rd    <= rd;
      s1.wen   <= wen;
   end

   assign prod = sext_pp(s1.pp_ll)
               + (sext_pp(s1.pp_lh) <<< 16)
               + (sext_pp(s1.pp_hl) <<< 16)
               + (sext_pp(s1.pp_hh) <<< 32);

   always_ff @(posedge clk) begin
      res     <= (s1.op == mul_lo) ? prod[31:0] : prod[63:32];
      rd_out  <= s1.rd;
      wen_out <= s1.wen;
   end

endmodule

/* source/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
   input  logic               clk,
   input  logic               rst_n,
   input  exu_pkg::wb_t       wb,
   input  exu_pkg::reg_addr_t raddr0,
   input  exu_pkg::reg_addr_t raddr1,
   output exu_pkg::data_t     rdata0,
   output exu_pkg::data_t     rdata1
);
   import exu_pkg::*;

   data_t regs [reg_count];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.wen) begin
         regs[wb.rd] <= wb.data;
      end
   end

   // no bypass, a write shows up after the edge
   assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
   assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

   // the control block filters r0 before the write port
   a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
      wb.wen |-> (wb.rd != '0))
      else $error("reg_file: write request aimed at r0");

endmodule

/* ecl/exu_ecl.sv */
`timescale 1ns/100ps

module exu_ecl (
   input  logic                    clk,
   input  logic                    rst_n,
   input  exu_pkg::exu_issue_t     issue,

   output exu_pkg::data_t          alu_a,
   output exu_pkg::data_t          alu_b,
   output exu_pkg::alu_op_t        alu_op,
   input  exu_pkg::data_t          alu_res,

   output exu_pkg::bru_op_t        bru_op,
   output exu_pkg::data_t          bru_a,
   output exu_pkg::data_t          bru_b,
   output exu_pkg::data_t          bru_pc,
   output exu_pkg::data_t          bru_offset,
   output logic                    bru_valid,
   input  exu_pkg::br_redirect_t   redirect_in,
   input  exu_pkg::data_t          link_pc,
   output exu_pkg::br_redirect_t   redirect,

   output logic                    mul_valid,
   output exu_pkg::data_t          mul_a,
   output exu_pkg::data_t          mul_b,
   output exu_pkg::mul_op_t        mul_op,
   input  exu_pkg::data_t          mul_res,
   input  logic                    mul_done,
   input  exu_pkg::reg_addr_t      mul_rd,
   input  logic                    mul_wen,

   output exu_pkg::wb_t            wb
);
   import exu_pkg::*;

   logic alu_valid;
   logic m_valid;
   wb_t  m_stage;
   logic w_valid;
   wb_t  w_stage;
   wb_t  wb_pick;

   // unit decode
   assign alu_valid = issue.valid && (issue.unit == unit_alu);
   assign bru_valid = issue.valid && (issue.unit == unit_bru);
   assign mul_valid = issue.valid && (issue.unit == unit_mul);

   assign alu_a  = issue.a;
   assign alu_b  = issue.b;
   assign alu_op = issue.alu_op;

   assign bru_op     = issue.bru_op;
   assign bru_a      = issue.a;
   assign bru_b      = issue.b;
   assign bru_pc     = issue.pc;
   assign bru_offset = issue.offset;

   assign mul_a  = issue.a;
   assign mul_b  = issue.b;
   assign mul_op = issue.mul_op;

   // redirect goes out in the issue cycle
   assign redirect = redirect_in;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         m_valid <= 1'b0;
         w_valid <= 1'b0;
      end else begin
         m_valid <= alu_valid | bru_valid;
         w_valid <= m_valid;
      end
   end

   // alu and link results wait two stages to line up with the multiplier
   always_ff @(posedge clk) begin
      m_stage.wen  <= issue.wen;
      m_stage.rd   <= issue.rd;
      m_stage.data <= bru_valid ? link_pc : alu_res;
      w_stage      <= m_stage;
   end

   always_comb begin
      if (mul_done) begin
         wb_pick.wen  = mul_wen;
         wb_pick.rd   = mul_rd;
         wb_pick.data = mul_res;
      end else begin
         wb_pick.wen  = w_valid & w_stage.wen;
         wb_pick.rd   = w_stage.rd;
         wb_pick.data = w_stage.data;
      end
   end

   // r0 writes are dropped here
   assign wb.wen  = wb_pick.wen & (wb_pick.rd != '0);
   assign wb.rd   = wb_pick.rd;
   assign wb.data = wb_pick.data;

   // one instruction per issue slot, so only one writer can retire
   a_single_writer: assert property (@(posedge clk) disable iff (!rst_n)
      !(w_valid && mul_done))
      else $error("exu_ecl: W stage and multiplier retire in the same cycle");

endmodule

/* source/exu.sv */
`timescale 1ns/100ps

module exu (
   input  logic                    clk,
   input  logic                    rst_n,
   input  exu_pkg::exu_issue_t     issue,
   input  exu_pkg::reg_addr_t      rs1_addr,
   input  exu_pkg::reg_addr_t      rs2_addr,
   output exu_pkg::data_t          rs1_data,
   output exu_pkg::data_t          rs2_data,
   output exu_pkg::br_redirect_t   redirect
);
   import exu_pkg::*;

   data_t        alu_a;
   data_t        alu_b;
   alu_op_t      alu_op;
   data_t        alu_res;

   bru_op_t      bru_op;
   data_t        bru_a;
   data_t        bru_b;
   data_t        bru_pc;
   data_t        bru_offset;
   logic         bru_valid;
   br_redirect_t bru_redirect;
   data_t        link_pc;

   logic         mul_valid;
   data_t        mul_a;
   data_t        mul_b;
   mul_op_t      mul_op;
   data_t        mul_res;
   logic         mul_done;
   reg_addr_t    mul_rd;
   logic         mul_wen;

   wb_t          wb;

   exu_ecl u_ecl (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue       (issue),
      .alu_a       (alu_a),
      .alu_b       (alu_b),
      .alu_op      (alu_op),
      .alu_res     (alu_res),
      .bru_op      (bru_op),
      .bru_a       (bru_a),
      .bru_b       (bru_b),
      .bru_pc      (bru_pc),
      .bru_offset  (bru_offset),
      .bru_valid   (bru_valid),
      .redirect_in (bru_redirect),
      .link_pc     (link_pc),
      .redirect    (redirect),
      .mul_valid   (mul_valid),
      .mul_a       (mul_a),
      .mul_b       (mul_b),
      .mul_op      (mul_op),
      .mul_res     (mul_res),
      .mul_done    (mul_done),
      .mul_rd      (mul_rd),
      .mul_wen     (mul_wen),
      .wb          (wb)
   );

   alu u_alu (
      .a   (alu_a),
      .b   (alu_b),
      .op  (alu_op),
      .res (alu_res)
   );

   branch_unit u_bru (
      .valid    (bru_valid),
      .op       (bru_op),
      .a        (bru_a),
      .b        (bru_b),
      .pc       (bru_pc),
      .offset   (bru_offset),
      .redirect (bru_redirect),
      .link_pc  (link_pc)
   );

   // rd and wen ride along the multiplier pipeline
   mul_pipe u_mul (
      .clk     (clk),
      .rst_n   (rst_n),
      .valid   (mul_valid),
      .a       (mul_a),
      .b       (mul_b),
      .op      (mul_op),
      .rd      (issue.rd),
      .wen     (issue.wen),
      .res     (mul_res),
      .done    (mul_done),
      .rd_out  (mul_rd),
      .wen_out (mul_wen)
   );

   reg_file u_reg_file (
      .clk    (clk),
      .rst_n  (rst_n),
      .wb     (wb),
      .raddr0 (rs1_addr),
      .raddr1 (rs2_addr),
      .rdata0 (rs1_data),
      .rdata1 (rs2_data)
   );

endmodule

/* dv/tb_exu.sv */
`timescale 1ns/100ps

module tb_exu;
   import exu_pkg::*;

   localparam int clk_period   = 20;
   localparam int reset_cycles = 5;
   // edges from driving an issue to reading its result back
   localparam int read_lag     = 3;
   // one edge earlier the destination still holds its old value
   localparam int hold_lag     = read_lag - 1;

   typedef struct packed {
      exu_issue_t   issue;
      data_t        exp_word;
      data_t        prev_word;
      br_redirect_t exp_redirect;
   } stim_t;

   logic         clk;
   logic         rst_n;
   exu_issue_t   issue;
   reg_addr_t    rs1_addr;
   reg_addr_t    rs2_addr;
   data_t        rs1_data;
   data_t        rs2_data;
   br_redirect_t redirect;

   stim_t        stim [$];
   data_t        model_regs [reg_count];
   logic         stim_ready;
   int unsigned  seed;

   exu i_exu (
      .clk      (clk),
      .rst_n    (rst_n),
      .issue    (issue),
      .rs1_addr (rs1_addr),
      .rs2_addr (rs2_addr),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .redirect (redirect)
   );

   always #(clk_period / 2) clk = ~clk;

   task automatic stop_on_error(input string reason);
      $display("%s", reason);
      $display("Regression failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_redirect(input string name, input br_redirect_t got,
                                 input br_redirect_t exp);
      if (got.taken !== exp.taken || (exp.taken && got.target !== exp.target)) begin
         stop_on_error($sformatf("mismatch %s: got taken %h target %h expected taken %h target %h",
                                 name, got.taken, got.target, exp.taken, exp.target));
      end
   endtask

   function automatic data_t shift_right_arith(data_t a, logic [4:0] sh);
      data_t fill;
      fill = a[31] ? ~(32'hffff_ffff >> sh) : '0;
      return (a >> sh) | fill;
   endfunction

   // register value after this instruction retires
   function automatic data_t expect_word(exu_issue_t e, data_t prev);
      logic [63:0] uprod;
      logic [63:0] sprod;
      data_t       r;
      if (!e.valid || !e.wen || e.rd == '0) begin
         return prev;
      end
      uprod = {32'h0, e.a} * {32'h0, e.b};
      sprod = {{32{e.a[31]}}, e.a} * {{32{e.b[31]}}, e.b};
      r = prev;
      case (e.unit)
         unit_alu: begin
            case (e.alu_op)
               alu_add:    r = e.a + e.b;
               alu_sub:    r = e.a - e.b;
               alu_slt:    r = ((e.a ^ 32'h8000_0000) < (e.b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
               alu_sltu:   r = (e.a < e.b) ? 32'd1 : 32'd0;
               alu_and:    r = e.a & e.b;
               alu_or:     r = e.a | e.b;
               alu_xor:    r = e.a ^ e.b;
               alu_nor:    r = ~(e.a | e.b);
               alu_sll:    r = e.a << e.b[4:0];
               alu_srl:    r = e.a >> e.b[4:0];
               alu_sra:    r = shift_right_arith(e.a, e.b[4:0]);
               default:    r = e.b;
            endcase
         end
         unit_bru: begin
            if (e.bru_op == bru_bl || e.bru_op == bru_jirl) begin
               r = e.pc + 32'd4;
            end
         end
         default: begin
            case (e.mul_op)
               mul_lo:   r = uprod[31:0];
               mul_hi_s: r = sprod[63:32];
               default:  r = uprod[63:32];
            endcase
         end
      endcase
      return r;
   endfunction

   function automatic br_redirect_t expect_redirect(exu_issue_t e);
      logic         lt_s;
      logic         cond;
      br_redirect_t r;
      lt_s = (e.a ^ 32'h8000_0000) < (e.b ^ 32'h8000_0000);
      case (e.bru_op)
         bru_beq:  cond = (e.a == e.b);
         bru_bne:  cond = (e.a != e.b);
         bru_blt:  cond = lt_s;
         bru_bge:  cond = !lt_s;
         bru_bltu: cond = (e.a < e.b);
         bru_bgeu: cond = !(e.a < e.b);
         default:  cond = 1'b1;
      endcase
      r.taken  = e.valid && (e.unit == unit_bru) && cond;
      r.target = ((e.bru_op == bru_jirl) ? e.a : e.pc) + e.offset;
      return r;
   endfunction

   function automatic exu_issue_t make_inst(logic valid, unit_t unit, data_t a, data_t b,
                                            reg_addr_t rd, logic wen);
      exu_issue_t e;
      e       = '0;
      e.valid = valid;
      e.unit  = unit;
      e.a     = a;
      e.b     = b;
      e.rd    = rd;
      e.wen   = wen;
      return e;
   endfunction

   task automatic add_entry(input exu_issue_t e);
      stim_t s;
      s.issue        = e;
      s.prev_word    = model_regs[e.rd];
      s.exp_word     = expect_word(e, model_regs[e.rd]);
      s.exp_redirect = expect_redirect(e);
      model_regs[e.rd] = s.exp_word;
      stim.push_back(s);
   endtask

   task automatic add_alu(input alu_op_t op, input data_t a, input data_t b,
                          input reg_addr_t rd, input logic wen);
      exu_issue_t e;
      e = make_inst(1'b1, unit_alu, a, b, rd, wen);
      e.alu_op = op;
      add_entry(e);
   endtask

   task automatic add_bru(input bru_op_t op, input data_t a, input data_t b,
                          input data_t offset, input reg_addr_t rd, input logic wen);
      exu_issue_t e;
      e = make_inst(1'b1, unit_bru, a, b, rd, wen);
      e.bru_op = op;
      e.pc     = 32'h1c00_0100;
      e.offset = offset;
      add_entry(e);
   endtask

   task automatic add_mul(input mul_op_t op, input data_t a, input data_t b,
                          input reg_addr_t rd, input logic wen);
      exu_issue_t e;
      e = make_inst(1'b1, unit_mul, a, b, rd, wen);
      e.mul_op = op;
      add_entry(e);
   endtask

   initial begin
      data_t ra;
      data_t rb;
      clk        = 1'b0;
      rst_n      = 1'b0;
      issue      = '0;
      rs1_addr   = '0;
      rs2_addr   = '0;
      stim_ready = 1'b0;
      seed       = 32'hb203_fcd0;
      void'($urandom(seed));
      for (int i = 0; i < reg_count; i++) begin
         model_regs[i] = '0;
      end

      // every register reads zero out of reset
      for (int i = 0; i < reg_count; i++) begin
         add_entry(make_inst(1'b0, unit_alu, '0, '0, reg_addr_t'(i), 1'b0));
      end
      add_alu(alu_add, 32'h1234_5678, 32'h0fed_cba8, 5'd1, 1'b1);
      add_alu(alu_sub, 32'd5, 32'd7, 5'd2, 1'b1);
      add_alu(alu_slt, 32'hffff_ffff, 32'd1, 5'd3, 1'b1);
      add_alu(alu_sltu, 32'hffff_ffff, 32'd1, 5'd4, 1'b1);
      add_alu(alu_slt, 32'd1, 32'hffff_ffff, 5'd5, 1'b1);
      add_alu(alu_sltu, 32'd1, 32'hffff_ffff, 5'd6, 1'b1);
      add_alu(alu_and, 32'hf0f0_1234, 32'h0ff0_ff00, 5'd7, 1'b1);
      add_alu(alu_or, 32'hf0f0_1234, 32'h0ff0_ff00, 5'd8, 1'b1);
      add_alu(alu_xor, 32'hf0f0_1234, 32'h0ff0_ff00, 5'd9, 1'b1);
      add_alu(alu_nor, 32'hf0f0_1234, 32'h0ff0_ff00, 5'd10, 1'b1);
      // shift amount takes only the low five bits
      add_alu(alu_sll, 32'h8000_0001, 32'h0000_0024, 5'd11, 1'b1);
      add_alu(alu_srl, 32'hf000_0000, 32'd8, 5'd12, 1'b1);
      add_alu(alu_sra, 32'hf000_0000, 32'd8, 5'd13, 1'b1);
      add_alu(alu_sra, 32'h7000_0000, 32'd4, 5'd14, 1'b1);
      add_alu(alu_pass_b, 32'h1111_1111, 32'habcd_e000, 5'd15, 1'b1);

      add_bru(bru_beq, 32'd9, 32'd9, 32'h40, 5'd0, 1'b0);
      add_bru(bru_beq, 32'd9, 32'd8, 32'h40, 5'd0, 1'b0);
      add_bru(bru_bne, 32'd9, 32'd8, 32'h40, 5'd0, 1'b0);
      add_bru(bru_bne, 32'd9, 32'd9, 32'h40, 5'd0, 1'b0);
      add_bru(bru_blt, 32'hffff_fffe, 32'd1, 32'hffff_ff00, 5'd0, 1'b0);
      add_bru(bru_bltu, 32'hffff_fffe, 32'd1, 32'h40, 5'd0, 1'b0);
      add_bru(bru_bge, 32'hffff_fffe, 32'd1, 32'h40, 5'd0, 1'b0);
      add_bru(bru_bge, 32'd3, 32'd3, 32'h80, 5'd0, 1'b0);
      add_bru(bru_bgeu, 32'hffff_fffe, 32'd1, 32'h80, 5'd0, 1'b0);
      add_bru(bru_bgeu, 32'd1, 32'd2, 32'h80, 5'd0, 1'b0);
      add_bru(bru_b, 32'd0, 32'd0, 32'h0000_1000, 5'd0, 1'b0);
      add_bru(bru_bl, 32'd0, 32'd0, 32'h0000_2000, 5'd20, 1'b1);
      add_bru(bru_jirl, 32'h1c00_2000, 32'd0, 32'hffff_fff8, 5'd21, 1'b1);

      for (int i = 0; i < 9; i++) begin
         ra = $urandom;
         rb = $urandom;
         if (i % 2 == 1) begin
            ra = ra | 32'h8000_0000;
         end
         add_mul(mul_op_t'(i % 3), ra, rb, reg_addr_t'(22 + i), 1'b1);
      end

      // multiply, alu, multiply in consecutive cycles
      add_mul(mul_lo, $urandom, $urandom, 5'd16, 1'b1);
      add_alu(alu_add, 32'h0000_ffff, 32'h0000_0001, 5'd17, 1'b1);
      add_mul(mul_hi_u, $urandom | 32'h8000_0000, $urandom, 5'd18, 1'b1);

      // writes that must not land
      add_alu(alu_add, 32'h5555_5555, 32'd1, 5'd0, 1'b1);
      add_alu(alu_add, 32'h5555_5555, 32'd1, 5'd1, 1'b0);
      add_mul(mul_lo, 32'd7, 32'd6, 5'd0, 1'b1);
      add_mul(mul_lo, 32'd7, 32'd6, 5'd2, 1'b0);
      add_entry(make_inst(1'b0, unit_alu, '0, '0, 5'd0, 1'b0));
      stim_ready = 1'b1;

      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;

      for (int c = 0; c < stim.size() + read_lag; c++) begin
         @(posedge clk);
         if (c < stim.size()) begin
            issue <= stim[c].issue;
         end else begin
            issue <= '0;
         end
         if (c >= read_lag) begin
            rs1_addr <= stim[c - read_lag].issue.rd;
         end
         if (c >= hold_lag && c - hold_lag < stim.size()) begin
            rs2_addr <= stim[c - hold_lag].issue.rd;
         end
         @(negedge clk);
         if (c < stim.size()) begin
            check_redirect($sformatf("redirect[%0d]", c), redirect, stim[c].exp_redirect);
         end
         if (c >= read_lag) begin
            check_word($sformatf("rs1_data[%0d] r%0d", c - read_lag, rs1_addr),
                       rs1_data, stim[c - read_lag].exp_word);
         end
         // the write has not landed yet one edge before its slot
         if (c >= hold_lag && c - hold_lag < stim.size()) begin
            check_word($sformatf("rs2_data[%0d] r%0d", c - hold_lag, rs2_addr),
                       rs2_data, stim[c - hold_lag].prev_word);
         end
      end

      $display("Regression passed");
      $finish;
   end

   initial begin
      wait (stim_ready);
      #((stim.size() + 10) * clk_period);
      stop_on_error("timeout: the test sequence did not complete in time");
   end

endmodule

/* exu.f */
common/exu_pkg.sv
source/alu.sv
source/branch_unit.sv
source/mul_pipe.sv
source/reg_file.sv
ecl/exu_ecl.sv
source/exu.sv
dv/tb_exu.sv
